/* dehaze_defs.svh */
`ifndef DEHAZE_DEFS_SVH
`define DEHAZE_DEFS_SVH

// image geometry
`define IMG_SIDE 8
`define COORD_W 3               // enough for IMG_SIDE positions
`define ADDR_W 6                // y and x side by side

`define PIX_W 8
`define PIX_MAX ((1 << `PIX_W) - 1)

// transmission, percent
`define T_MIN 25
`define T_SPAN 75
`define T_STEP 5                // width of one factor bucket
`define TRANS_W 7

`define FACTOR_SHIFT 4          // factor is in sixteenths
`define FACTOR_W 7

`endif

/* pixel_pkg.sv */
`include "dehaze_defs.svh"

package pixel_pkg;

    typedef logic [`PIX_W-1:0] channel_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    typedef logic [`PIX_W-1:0] dark_t;
    typedef logic [`TRANS_W-1:0] trans_t;     // 25 to 100
    typedef logic [`FACTOR_W-1:0] factor_t;
    typedef logic [3:0] bucket_t;

    localparam int NUM_BUCKETS = 15;

    // roughly 1/t in sixteenths, bucket k covers t = 25 + 5k
    localparam factor_t FACTOR_TABLE [NUM_BUCKETS] = '{
        7'd64, 7'd48, 7'd43, 7'd38, 7'd34,
        7'd32, 7'd29, 7'd26, 7'd24, 7'd22,
        7'd21, 7'd19, 7'd18, 7'd18, 7'd16
    };

endpackage

/* dehaze_ctrl_pkg.sv */
`include "dehaze_defs.svh"

package dehaze_ctrl_pkg;

    typedef logic [`COORD_W-1:0] coord_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef enum logic [2:0] {
        LOAD,
        DARK,
        TRANS,
        OUTPUT,
        FINISH
    } pass_state_t;

    typedef enum logic [1:0] {
        HOLD,       // only load strobes move the position
        INTERIOR,
        FULL
    } walk_mode_t;

    function automatic addr_t pos_addr(pos_t p);
        return addr_t'(p.y * `IMG_SIDE + p.x);
    endfunction

endpackage

/* dehaze_fsm.sv */
`timescale 1ns/1ns
`include "dehaze_defs.svh"

module dehaze_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic                        last_pos,
    output dehaze_ctrl_pkg::walk_mode_t walk_mode,
    output logic                        load_step,
    output logic                        dark_en,
    output logic                        trans_en,
    output logic                        out_en,
    output logic                        busy,
    output logic                        done
);

    localparam dehaze_ctrl_pkg::addr_t LAST_ADDR =
        dehaze_ctrl_pkg::addr_t'(`IMG_SIDE * `IMG_SIDE - 1);

    dehaze_ctrl_pkg::pass_state_t state;
    dehaze_ctrl_pkg::pass_state_t next_state;
    dehaze_ctrl_pkg::addr_t       load_cnt;
    logic                         drained;    // output register flushed

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= dehaze_ctrl_pkg::LOAD;
            load_cnt <= '0;
            drained  <= 1'b0;
        end else begin
            state <= next_state;
            if (load_step) begin
                load_cnt <= load_cnt + 1'b1;    // wraps after the last pixel
            end
            drained <= (state == dehaze_ctrl_pkg::FINISH) && !drained;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dehaze_ctrl_pkg::LOAD: begin
                if (load_step && load_cnt == LAST_ADDR) begin
                    next_state = dehaze_ctrl_pkg::DARK;
                end
            end
            dehaze_ctrl_pkg::DARK: begin
                if (last_pos) begin
                    next_state = dehaze_ctrl_pkg::TRANS;
                end
            end
            dehaze_ctrl_pkg::TRANS: begin
                if (last_pos) begin
                    next_state = dehaze_ctrl_pkg::OUTPUT;
                end
            end
            dehaze_ctrl_pkg::OUTPUT: begin
                if (last_pos) begin
                    next_state = dehaze_ctrl_pkg::FINISH;
                end
            end
            // first cycle lets the last pixel leave the output register
            dehaze_ctrl_pkg::FINISH: begin
                if (drained) begin
                    next_state = dehaze_ctrl_pkg::LOAD;
                end
            end
            default: next_state = dehaze_ctrl_pkg::LOAD;
        endcase
    end

    always_comb begin
        case (state)
            dehaze_ctrl_pkg::DARK,
            dehaze_ctrl_pkg::TRANS:  walk_mode = dehaze_ctrl_pkg::INTERIOR;
            dehaze_ctrl_pkg::OUTPUT: walk_mode = dehaze_ctrl_pkg::FULL;
            default:                 walk_mode = dehaze_ctrl_pkg::HOLD;
        endcase
    end

    assign load_step = in_valid && (state == dehaze_ctrl_pkg::LOAD);  // ignored otherwise
    assign dark_en   = state == dehaze_ctrl_pkg::DARK;
    assign trans_en  = state == dehaze_ctrl_pkg::TRANS;
    assign out_en    = state == dehaze_ctrl_pkg::OUTPUT;
    assign busy      = state != dehaze_ctrl_pkg::LOAD;
    assign done      = (state == dehaze_ctrl_pkg::FINISH) && drained;

endmodule

/* raster_counter.sv */
`timescale 1ns/1ns
`include "dehaze_defs.svh"

module raster_counter #(
    parameter int SIDE = `IMG_SIDE
) (
    input  logic                        clk,
    input  logic                        rst,
    input  dehaze_ctrl_pkg::walk_mode_t walk_mode,
    input  logic                        load_step,
    output dehaze_ctrl_pkg::pos_t       pos,
    output logic                        last_pos
);

    // cx, cy count from the origin of the current walk
    localparam dehaze_ctrl_pkg::coord_t FULL_END  = dehaze_ctrl_pkg::coord_t'(SIDE - 1);
    localparam dehaze_ctrl_pkg::coord_t INNER_END = dehaze_ctrl_pkg::coord_t'(SIDE - 3);

    dehaze_ctrl_pkg::coord_t cx;
    dehaze_ctrl_pkg::coord_t cy;
    dehaze_ctrl_pkg::coord_t end_c;
    logic                    interior;
    logic                    at_end;
    logic                    step;

    always_comb begin
        interior = walk_mode == dehaze_ctrl_pkg::INTERIOR;
        end_c    = interior ? INNER_END : FULL_END;
        at_end   = (cx == end_c) && (cy == end_c);
        step     = load_step || (walk_mode != dehaze_ctrl_pkg::HOLD);
        last_pos = at_end && (walk_mode != dehaze_ctrl_pkg::HOLD);
        pos.x    = interior ? cx + 1'b1 : cx;   // interior walk skips the border
        pos.y    = interior ? cy + 1'b1 : cy;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cx <= '0;
            cy <= '0;
        end else if (step) begin
            if (at_end) begin
                // origin of the next walk, whatever its mode
                cx <= '0;
                cy <= '0;
            end else if (cx == end_c) begin
                cx <= '0;
                cy <= cy + 1'b1;
            end else begin
                cx <= cx + 1'b1;
            end
        end
    end

endmodule

/* frame_buffer.sv */
`timescale 1ns/1ns
`include "dehaze_defs.svh"

module frame_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  dehaze_ctrl_pkg::pos_t pos,
    input  pixel_pkg::rgb_t       wr_pixel,
    output pixel_pkg::rgb_t [8:0] window,
    output pixel_pkg::rgb_t       centre
);

    localparam int DEPTH = `IMG_SIDE * `IMG_SIDE;

    pixel_pkg::rgb_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en && !rst) begin
            mem[dehaze_ctrl_pkg::pos_addr(pos)] <= wr_pixel;
        end
    end

    // window[3*dy + dx], taps wrap around on the border
    // where the window is never used
    always_comb begin
        dehaze_ctrl_pkg::pos_t tap;
        tap = pos;
        for (int dy = 0; dy < 3; dy++) begin
            for (int dx = 0; dx < 3; dx++) begin
                tap.x = dehaze_ctrl_pkg::coord_t'(pos.x + dx - 1);
                tap.y = dehaze_ctrl_pkg::coord_t'(pos.y + dy - 1);
                window[dy * 3 + dx] = mem[dehaze_ctrl_pkg::pos_addr(tap)];
            end
        end
        centre = mem[dehaze_ctrl_pkg::pos_addr(pos)];
    end

endmodule

/* dark_channel.sv */
`timescale 1ns/1ns
`include "dehaze_defs.svh"

module dark_channel (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dark_en,
    input  dehaze_ctrl_pkg::pos_t pos,
    input  pixel_pkg::rgb_t [8:0] window,
    output pixel_pkg::dark_t      dark
);

    localparam int DEPTH = `IMG_SIDE * `IMG_SIDE;

    pixel_pkg::dark_t dark_mem [DEPTH];
    pixel_pkg::dark_t win_min;

    function automatic pixel_pkg::dark_t min2(pixel_pkg::dark_t a, pixel_pkg::dark_t b);
        return (a < b) ? a : b;
    endfunction

    // min over nine pixels of min(r, g, b)
    always_comb begin
        win_min = '1;
        for (int i = 0; i < 9; i++) begin
            win_min = min2(win_min, min2(window[i].r, min2(window[i].g, window[i].b)));
        end
    end

    always_ff @(posedge clk) begin
        if (dark_en && !rst) begin
            dark_mem[dehaze_ctrl_pkg::pos_addr(pos)] <= win_min;
        end
    end

    assign dark = dark_mem[dehaze_ctrl_pkg::pos_addr(pos)];

endmodule

/* transmission_map.sv */
`timescale 1ns/1ns
`include "dehaze_defs.svh"

module transmission_map (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  trans_en,
    input  dehaze_ctrl_pkg::pos_t pos,
    input  pixel_pkg::dark_t      dark,
    output pixel_pkg::trans_t     t
);

    localparam int DEPTH  = `IMG_SIDE * `IMG_SIDE;
    localparam int PROD_W = `PIX_W + `TRANS_W;

    logic [PROD_W-1:0] prod;
    logic [PROD_W-1:0] quot;
    pixel_pkg::trans_t t_new;
    pixel_pkg::trans_t t_mem [DEPTH];

    // t = 25 + floor(dark * 75 / 255)
    always_comb begin
        prod = PROD_W'(dark) * PROD_W'(`T_SPAN);
        // divide by 255 with shifts, exact while the quotient stays below 256
        quot  = (prod + PROD_W'(1) + (prod >> `PIX_W)) >> `PIX_W;
        t_new = pixel_pkg::trans_t'(`T_MIN) + pixel_pkg::trans_t'(quot);
    end

    // only interior positions are walked here
    always_ff @(posedge clk) begin
        if (trans_en && !rst) begin
            t_mem[dehaze_ctrl_pkg::pos_addr(pos)] <= t_new;
        end
    end

    assign t = t_mem[dehaze_ctrl_pkg::pos_addr(pos)];

endmodule

/* radiance_recovery.sv */
`timescale 1ns/1ns
`include "dehaze_defs.svh"

module radiance_recovery (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  out_en,
    input  dehaze_ctrl_pkg::pos_t pos,
    input  pixel_pkg::trans_t     t,
    input  pixel_pkg::rgb_t       centre,
    output logic                  out_valid,
    output pixel_pkg::rgb_t       out_pixel
);

    localparam int PROD_W = `PIX_W + `FACTOR_W;
    localparam dehaze_ctrl_pkg::coord_t EDGE = dehaze_ctrl_pkg::coord_t'(`IMG_SIDE - 1);
    localparam pixel_pkg::trans_t CAP_OFF =
        pixel_pkg::trans_t'(`T_STEP * (pixel_pkg::NUM_BUCKETS - 1));

    pixel_pkg::trans_t  t_off;
    pixel_pkg::bucket_t bucket;
    pixel_pkg::factor_t factor;
    logic               border;
    pixel_pkg::rgb_t    recovered;
    pixel_pkg::rgb_t    next_pixel;

    // 255 - min(255, ((255 - ch) * f) >> 4)
    function automatic pixel_pkg::channel_t recover(pixel_pkg::channel_t ch,
                                                    pixel_pkg::factor_t f);
        logic [PROD_W-1:0] scaled;
        scaled = (PROD_W'(`PIX_MAX - ch) * PROD_W'(f)) >> `FACTOR_SHIFT;
        if (scaled > PROD_W'(`PIX_MAX)) begin
            scaled = PROD_W'(`PIX_MAX);     // saturate
        end
        return pixel_pkg::channel_t'(`PIX_MAX - scaled);
    endfunction

    always_comb begin
        t_off = t - pixel_pkg::trans_t'(`T_MIN);
        if (t_off >= CAP_OFF) begin
            bucket = pixel_pkg::bucket_t'(pixel_pkg::NUM_BUCKETS - 1);
        end else begin
            bucket = pixel_pkg::bucket_t'(t_off / `T_STEP);
        end
        factor      = pixel_pkg::FACTOR_TABLE[bucket];
        recovered.r = recover(centre.r, factor);
        recovered.g = recover(centre.g, factor);
        recovered.b = recover(centre.b, factor);
        border      = (pos.x == '0) || (pos.y == '0) || (pos.x == EDGE) || (pos.y == EDGE);
        next_pixel  = border ? centre : recovered;    // border copied as loaded
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= out_en;
        end
    end

    always_ff @(posedge clk) begin
        if (out_en) begin
            out_pixel <= next_pixel;
        end
    end

endmodule

/* dehaze_top.sv */
`timescale 1ns/1ns

module dehaze_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  pixel_pkg::rgb_t in_pixel,
    output logic            busy,
    output logic            out_valid,
    output pixel_pkg::rgb_t out_pixel,
    output logic            done
);

    dehaze_ctrl_pkg::walk_mode_t walk_mode;
    dehaze_ctrl_pkg::pos_t       pos;
    logic                        last_pos;
    logic                        load_step;
    logic                        dark_en;
    logic                        trans_en;
    logic                        out_en;
    pixel_pkg::rgb_t [8:0]       window;
    pixel_pkg::rgb_t             centre;
    pixel_pkg::dark_t            dark;
    pixel_pkg::trans_t           t;

    dehaze_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .last_pos  (last_pos),
        .walk_mode (walk_mode),
        .load_step (load_step),
        .dark_en   (dark_en),
        .trans_en  (trans_en),
        .out_en    (out_en),
        .busy      (busy),
        .done      (done)
    );

    raster_counter u_counter (
        .clk       (clk),
        .rst       (rst),
        .walk_mode (walk_mode),
        .load_step (load_step),
        .pos       (pos),
        .last_pos  (last_pos)
    );

    frame_buffer u_frame (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (load_step),
        .pos      (pos),
        .wr_pixel (in_pixel),
        .window   (window),
        .centre   (centre)
    );

    dark_channel u_dark (
        .clk     (clk),
        .rst     (rst),
        .dark_en (dark_en),
        .pos     (pos),
        .window  (window),
        .dark    (dark)
    );

    transmission_map u_trans (
        .clk      (clk),
        .rst      (rst),
        .trans_en (trans_en),
        .pos      (pos),
        .dark     (dark),
        .t        (t)
    );

    radiance_recovery u_recover (
        .clk       (clk),
        .rst       (rst),
        .out_en    (out_en),
        .pos       (pos),
        .t         (t),
        .centre    (centre),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

endmodule

/* dehaze_properties.sv */
`timescale 1ns/1ns

module dehaze_properties (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic busy,
    input logic out_valid,
    input logic done
);

    done_single_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // a write is only taken while idle
    no_write_during_output: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !(in_valid && !busy))
        else $error("out_valid high while a load write was accepted");

    busy_low_after_done: assert property (@(posedge clk) disable iff (rst)
        done |=> !busy)
        else $error("busy still high after done");

    busy_falls_on_done: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> $past(done))
        else $error("busy fell without done");

endmodule

bind dehaze_top dehaze_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .busy      (busy),
    .out_valid (out_valid),
    .done      (done)
);

/* dehaze_tb.sv */
`timescale 1ns/1ns
`include "dehaze_defs.svh"

module dehaze_tb;

    localparam int NPIX  = `IMG_SIDE * `IMG_SIDE;
    localparam int INNER = (`IMG_SIDE - 2) * (`IMG_SIDE - 2);
    // load with up to two idle cycles per pixel, three passes, drain
    localparam int RUN_CYCLES = 3 * NPIX + 2 * INNER + NPIX + 8;
    localparam int MAX_CYCLES = 6 * RUN_CYCLES + 16;

    localparam int UNIFORM  = 0;
    localparam int GRADIENT = 1;
    localparam int RANDOM   = 2;

    logic            clk = 1'b0;
    logic            rst;
    logic            in_valid;
    pixel_pkg::rgb_t in_pixel;
    logic            busy;
    logic            out_valid;
    pixel_pkg::rgb_t out_pixel;
    logic            done;

    pixel_pkg::rgb_t img [$];
    int              factor_by_bucket [$] = {64, 48, 43, 38, 34, 32, 29, 26,
                                             24, 22, 21, 19, 18, 18, 16};
    logic [31:0]     lcg_state = 32'heac;
    int              cycles = 0;

    dehaze_top dehaze_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pixel  (in_pixel),
        .busy      (busy),
        .out_valid (out_valid),
        .out_pixel (out_pixel),
        .done      (done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_pixel(input string test, input int idx,
                                 input pixel_pkg::rgb_t exp, input pixel_pkg::rgb_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s pixel %0d: expected %h actual %h",
                                    test, idx, exp, act));
        end
    endtask

    task automatic compare_flag(input string test, input string what,
                                input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s %s: expected %b actual %b",
                                    test, what, exp, act));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() >> 8) % n;   // upper bits, low ones cycle fast
    endfunction

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    function automatic int chan_min(input pixel_pkg::rgb_t p);
        return min_int(int'(p.r), min_int(int'(p.g), int'(p.b)));
    endfunction

    function automatic pixel_pkg::channel_t recover_chan(input pixel_pkg::channel_t ch,
                                                         input int f);
        int s;
        s = ((255 - int'(ch)) * f) >> `FACTOR_SHIFT;
        return pixel_pkg::channel_t'(255 - min_int(s, 255));
    endfunction

    // reference model: dark channel, transmission, bucketed factor
    function automatic pixel_pkg::rgb_t expected_pixel(input int x, input int y);
        pixel_pkg::rgb_t c;
        pixel_pkg::rgb_t e;
        int              dk;
        int              t;
        int              f;
        c = img[y * `IMG_SIDE + x];
        if (x == 0 || y == 0 || x == `IMG_SIDE - 1 || y == `IMG_SIDE - 1) begin
            return c;
        end
        dk = 255;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                dk = min_int(dk, chan_min(img[(y + dy) * `IMG_SIDE + x + dx]));
            end
        end
        t = `T_MIN + dk * `T_SPAN / 255;
        f = factor_by_bucket[min_int((t - `T_MIN) / 5, 14)];
        e.r = recover_chan(c.r, f);
        e.g = recover_chan(c.g, f);
        e.b = recover_chan(c.b, f);
        return e;
    endfunction

    function automatic pixel_pkg::rgb_t pattern_pixel(input int kind, input int a);
        pixel_pkg::rgb_t p;
        int              span;
        span = 16 + 24 * (a / `IMG_SIDE);    // lower rows spread wider
        p = '1;
        if (kind == GRADIENT) begin
            p.r = pixel_pkg::channel_t'(255 - a);
            p.g = pixel_pkg::channel_t'(255 - a);
            p.b = pixel_pkg::channel_t'(255 - a);
        end else if (kind == RANDOM) begin
            p.r = pixel_pkg::channel_t'(255 - rand_below(span));
            p.g = pixel_pkg::channel_t'(255 - rand_below(span));
            p.b = pixel_pkg::channel_t'(255 - rand_below(span));
        end
        return p;
    endfunction

    task automatic load_image(input string test, input bit gaps);
        @(posedge clk);
        #1;
        for (int a = 0; a < NPIX; a++) begin
            if (gaps) begin
                repeat (rand_below(3)) begin
                    @(posedge clk);
                    #1;
                end
            end
            in_valid = 1'b1;
            in_pixel = img[a];
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
        compare_flag(test, "busy after last write", 1'b1, busy);
    endtask

    // random strobes that must be ignored while busy
    task automatic drive_noise(input bit noise);
        in_valid = noise;
        if (noise) begin
            in_pixel = 24'(lcg_next() >> 8);
        end
    endtask

    task automatic collect_and_check(input string test, input bit noise);
        while (!out_valid) begin
            drive_noise(noise);
            @(posedge clk);
            #1;
        end
        for (int a = 0; a < NPIX; a++) begin
            if (a > 0) begin
                @(posedge clk);
                #1;
            end
            compare_flag(test, "out_valid", 1'b1, out_valid);
            compare_pixel(test, a, expected_pixel(a % `IMG_SIDE, a / `IMG_SIDE), out_pixel);
            drive_noise(noise);   // strobes go on through the output pass
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        compare_flag(test, "done after last output", 1'b1, done);
        compare_flag(test, "out_valid after last output", 1'b0, out_valid);
        @(posedge clk);
        #1;
        compare_flag(test, "done one cycle later", 1'b0, done);
        compare_flag(test, "busy after done", 1'b0, busy);
    endtask

    task automatic run_image(input string test, input int kind,
                             input bit gaps, input bit noise);
        img = {};
        for (int a = 0; a < NPIX; a++) begin
            img.push_back(pattern_pixel(kind, a));
        end
        load_image(test, gaps);
        collect_and_check(test, noise);
        $display("%s: finished", test);
    endtask

    task automatic test_after_reset();
        compare_flag("reset", "out_valid", 1'b0, out_valid);
        compare_flag("reset", "done", 1'b0, done);
        compare_flag("reset", "busy", 1'b0, busy);
    endtask

    task automatic test_uniform();
        run_image("uniform", UNIFORM, 1'b0, 1'b0);
    endtask

    task automatic test_gradient();
        run_image("gradient", GRADIENT, 1'b0, 1'b0);
    endtask

    task automatic test_random();
        run_image("random", RANDOM, 1'b0, 1'b0);
    endtask

    // strobes while busy, then a fresh image after done
    task automatic test_busy_strobes();
        run_image("busy strobes", RANDOM, 1'b0, 1'b1);
        run_image("after busy strobes", GRADIENT, 1'b0, 1'b0);
    endtask

    task automatic test_load_gaps();
        run_image("load gaps", RANDOM, 1'b1, 1'b0);
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_pixel = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_after_reset();
        test_uniform();
        test_gradient();
        test_random();
        test_busy_strobes();
        test_load_gaps();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
pixel_pkg.sv
dehaze_ctrl_pkg.sv
dehaze_fsm.sv
raster_counter.sv
frame_buffer.sv
dark_channel.sv
transmission_map.sv
radiance_recovery.sv
dehaze_top.sv
dehaze_properties.sv
dehaze_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dehaze testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module dehaze_tb -f verilog.f -o sim_dehaze
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_dehaze > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "*** FAILED ***" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
